// ==== rom_pkg.sv ====
/*
  Shared sizes, SDRAM layout and bus structs for the ROM fetch subsystem.
  Addresses are in 16-bit SDRAM units. REGION_OFFSET order is main, sound, char, obj.
*/
package rom_pkg;

    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);
    localparam int SDRAM_AW  = 22;
    localparam int WORD_AW   = SDRAM_AW - 1;
    localparam int CLIENT_AW = 17;

    // Base of each client's area in SDRAM, index 0 is the main CPU
    localparam logic [NUM_SLOTS-1:0][SDRAM_AW-1:0] REGION_OFFSET = {
        22'h4_0000 >> 1,
        22'h1_4000 >> 1,
        22'h1_8000 >> 1,
        22'h0_0000
    };

    typedef struct packed {
        logic                cs;
        logic [SDRAM_AW-1:0] addr;
    } rom_req_t;

    // Lower half holds the even address, upper half the odd one
    typedef struct packed {
        logic        rdy;
        logic [31:0] data;
    } sdram_rd_t;

    // Mask is active low
    typedef struct packed {
        logic                we;
        logic [SDRAM_AW-1:0] addr;
        logic [15:0]         data;
        logic [1:0]          mask;
    } prog_wr_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

endpackage

// ==== rom_region_map.sv ====
/*
  Client address translation. Output is one cycle behind the client inputs.
  Client addresses are zero extended before the region offset is added.
*/
`timescale 1ns/10ps

module rom_region_map (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [rom_pkg::NUM_SLOTS-1:0]                          client_cs,
    input  logic [rom_pkg::NUM_SLOTS-1:0][rom_pkg::CLIENT_AW-1:0]  client_addr,
    output rom_pkg::rom_req_t [rom_pkg::NUM_SLOTS-1:0]             slot_req
);
    import rom_pkg::*;

    logic [NUM_SLOTS-1:0]               cs_q;
    logic [NUM_SLOTS-1:0][SDRAM_AW-1:0] addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_q <= '0;
        end else begin
            cs_q <= client_cs;
        end
    end

    // Board ROM layout is fixed here
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            addr_q[i] <= REGION_OFFSET[i] + SDRAM_AW'(client_addr[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_req[i].cs   = cs_q[i];
            slot_req[i].addr = addr_q[i];
        end
    end

endmodule

// ==== rom_slot.sv ====
/*
  One 32-bit word cache for a single client. A miss is latched and held on
  fetch_req until the arbiter answers with fetch_grant_done.
  Cache contents are not invalidated by a download, only by reset.
*/
`timescale 1ns/10ps

module rom_slot (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rom_pkg::rom_req_t            req,
    output logic                         fetch_req,
    output logic [rom_pkg::SDRAM_AW-1:0] fetch_addr,
    input  logic                         fetch_grant_done,
    input  logic [31:0]                  fetch_data,
    output logic [15:0]                  data,
    output logic                         ok
);
    import rom_pkg::*;

    logic               valid;
    logic [WORD_AW-1:0] tag;
    logic [31:0]        word;
    logic [WORD_AW-1:0] pend_addr;
    logic [WORD_AW-1:0] req_word;
    logic               hit;
    logic               fill_match;
    logic               start_miss;
    logic [31:0]        word_next;

    assign req_word   = req.addr[SDRAM_AW-1:1];
    assign hit        = valid && (tag == req_word);
    assign fill_match = fetch_grant_done && (pend_addr == req_word);
    assign start_miss = req.cs && !hit && !fetch_req;
    // Bypass the fill word so ok can rise one cycle after the grant
    assign word_next  = fetch_grant_done ? fetch_data : word;
    assign fetch_addr = {pend_addr, 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            fetch_req <= 1'b0;
            ok        <= 1'b0;
        end else begin
            if (fetch_grant_done) begin
                valid     <= 1'b1;
                fetch_req <= 1'b0;
            end else if (start_miss) begin
                fetch_req <= 1'b1;
            end
            ok <= req.cs && (fill_match || (hit && !fetch_grant_done));
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_grant_done) begin
            tag  <= pend_addr;
            word <= fetch_data;
        end
        if (start_miss) begin
            pend_addr <= req_word;
        end
        data <= req.addr[0] ? word_next[31:16] : word_next[15:0];
    end

endmodule

// ==== rom_arbiter.sv ====
/*
  Round-robin SDRAM read arbiter with a single read in flight.
  No read starts while downloading is high or before rom_ready is back.
*/
`timescale 1ns/10ps

module rom_arbiter (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [rom_pkg::NUM_SLOTS-1:0]                         fetch_req,
    input  logic [rom_pkg::NUM_SLOTS-1:0][rom_pkg::SDRAM_AW-1:0]  fetch_addr,
    output logic [rom_pkg::NUM_SLOTS-1:0]                         fetch_grant_done,
    output logic [31:0]                                           fetch_data,
    input  logic                                                  downloading,
    output logic                                                  sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]                          sdram_addr,
    input  logic                                                  sdram_ack,
    input  rom_pkg::sdram_rd_t                                    sdram_rd,
    output logic                                                  rom_ready
);
    import rom_pkg::*;

    arb_state_e           state;
    logic [SLOT_W-1:0]    sel;
    logic [SLOT_W-1:0]    last;
    logic [SLOT_W-1:0]    next_sel;
    logic [NUM_SLOTS-1:0] pending;
    logic                 dl_q;
    logic                 start;

    // A slot being granted this cycle still shows fetch_req
    assign pending = fetch_req & ~fetch_grant_done;
    assign start   = (state == ARB_IDLE) && (|pending) && rom_ready && !downloading;

    // Search starts after the last served slot
    always_comb begin
        int idx;
        next_sel = last;
        for (int k = NUM_SLOTS; k >= 1; k--) begin
            idx = (int'(last) + k) % NUM_SLOTS;
            if (pending[idx]) begin
                next_sel = SLOT_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= ARB_IDLE;
            sel              <= '0;
            last             <= SLOT_W'(NUM_SLOTS - 1);
            sdram_req        <= 1'b0;
            fetch_grant_done <= '0;
            dl_q             <= 1'b1;
            rom_ready        <= 1'b0;
        end else begin
            dl_q             <= downloading;
            rom_ready        <= !dl_q;
            fetch_grant_done <= '0;
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        sel       <= next_sel;
                        sdram_req <= 1'b1;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (sdram_rd.rdy) begin
                        fetch_grant_done[sel] <= 1'b1;
                        last                  <= sel;
                        state                 <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= fetch_addr[next_sel];
        end
        if (state == ARB_WAIT_DATA && sdram_rd.rdy) begin
            fetch_data <= sdram_rd.data;
        end
    end

endmodule

// ==== rom_prog_loader.sv ====
/*
  Byte-wide ioctl writes become 16-bit masked SDRAM writes, one cycle later.
  ioctl_addr is a byte address; its low bit picks the byte lane.
*/
`timescale 1ns/10ps

module rom_prog_loader (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ioctl_wr,
    input  logic [rom_pkg::SDRAM_AW-1:0] ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    output rom_pkg::prog_wr_t            prog
);
    import rom_pkg::*;

    logic                we_q;
    logic [SDRAM_AW-1:0] addr_q;
    logic [15:0]         data_q;
    logic [1:0]          mask_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ioctl_wr;
        end
    end

    // Byte goes to both lanes, the mask selects one
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            addr_q <= ioctl_addr >> 1;
            data_q <= {ioctl_data, ioctl_data};
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign prog = '{we: we_q, addr: addr_q, data: data_q, mask: mask_q};

endmodule

// ==== rom_fetch_top.sv ====
/*
  ROM fetch subsystem top. Clients read game ROM through per-client word
  caches; the SDRAM controller itself is outside this block.
*/
`timescale 1ns/10ps

module rom_fetch_top (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [rom_pkg::NUM_SLOTS-1:0]                          client_cs,
    input  logic [rom_pkg::NUM_SLOTS-1:0][rom_pkg::CLIENT_AW-1:0]  client_addr,
    output logic [rom_pkg::NUM_SLOTS-1:0][15:0]                    client_data,
    output logic [rom_pkg::NUM_SLOTS-1:0]                          client_ok,
    input  logic                                                   downloading,
    input  logic                                                   ioctl_wr,
    input  logic [rom_pkg::SDRAM_AW-1:0]                           ioctl_addr,
    input  logic [7:0]                                             ioctl_data,
    output rom_pkg::prog_wr_t                                      prog,
    output logic                                                   sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]                           sdram_addr,
    input  logic                                                   sdram_ack,
    input  rom_pkg::sdram_rd_t                                     sdram_rd,
    output logic                                                   rom_ready
);
    import rom_pkg::*;

    rom_req_t [NUM_SLOTS-1:0]               slot_req;
    logic     [NUM_SLOTS-1:0]               fetch_req;
    logic     [NUM_SLOTS-1:0][SDRAM_AW-1:0] fetch_addr;
    logic     [NUM_SLOTS-1:0]               fetch_grant_done;
    logic     [31:0]                        fetch_data;

    rom_region_map u_map (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .client_cs   ( client_cs   ),
        .client_addr ( client_addr ),
        .slot_req    ( slot_req    )
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        rom_slot u_slot (
            .clk              ( clk                 ),
            .rst_n            ( rst_n               ),
            .req              ( slot_req[i]         ),
            .fetch_req        ( fetch_req[i]        ),
            .fetch_addr       ( fetch_addr[i]       ),
            .fetch_grant_done ( fetch_grant_done[i] ),
            .fetch_data       ( fetch_data          ),
            .data             ( client_data[i]      ),
            .ok               ( client_ok[i]        )
        );
    end

    rom_arbiter u_arb (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .fetch_req        ( fetch_req        ),
        .fetch_addr       ( fetch_addr       ),
        .fetch_grant_done ( fetch_grant_done ),
        .fetch_data       ( fetch_data       ),
        .downloading      ( downloading      ),
        .sdram_req        ( sdram_req        ),
        .sdram_addr       ( sdram_addr       ),
        .sdram_ack        ( sdram_ack        ),
        .sdram_rd         ( sdram_rd         ),
        .rom_ready        ( rom_ready        )
    );

    rom_prog_loader u_loader (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_data ( ioctl_data ),
        .prog       ( prog       )
    );

endmodule

// ==== rom_checker.sv ====
/*
  Watches the DUT ports and compares them with reference models.
  Client data is checked against the address sampled two cycles earlier.
*/
`timescale 1ns/10ps

module rom_checker (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [rom_pkg::NUM_SLOTS-1:0][rom_pkg::CLIENT_AW-1:0]  client_addr,
    input  logic [rom_pkg::NUM_SLOTS-1:0][15:0]                    client_data,
    input  logic [rom_pkg::NUM_SLOTS-1:0]                          client_ok,
    input  logic                                                   downloading,
    input  logic                                                   ioctl_wr,
    input  logic [rom_pkg::SDRAM_AW-1:0]                           ioctl_addr,
    input  logic [7:0]                                             ioctl_data,
    input  rom_pkg::prog_wr_t                                      prog,
    input  logic                                                   sdram_req,
    input  logic                                                   rom_ready,
    output int                                                     errors
);
    import rom_pkg::*;

    logic [15:0]                         shadow [logic [SDRAM_AW-1:0]];
    logic [NUM_SLOTS-1:0][CLIENT_AW-1:0] addr_h1;
    logic [NUM_SLOTS-1:0][CLIENT_AW-1:0] addr_h2;
    logic                                rst_h1;
    logic                                dl_h1;
    logic                                dl_h2;
    logic                                req_h1;
    logic                                wr_h1;
    logic [SDRAM_AW-1:0]                 waddr_h1;
    logic [7:0]                          wdata_h1;

    function automatic logic [15:0] stored_word(input logic [SDRAM_AW-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a[15:0] ^ 16'hA5C3;
    endfunction

    function automatic logic [15:0] expected_data(input int slot,
                                                  input logic [CLIENT_AW-1:0] a);
        return stored_word(REGION_OFFSET[slot] + SDRAM_AW'(a));
    endfunction

    // Byte address in, 16-bit write with the other byte masked out
    function automatic prog_wr_t expected_prog(input logic [SDRAM_AW-1:0] a,
                                               input logic [7:0] d);
        prog_wr_t p;
        p.we   = 1'b1;
        p.addr = a >> 1;
        p.data = {d, d};
        p.mask = a[0] ? 2'b01 : 2'b10;
        return p;
    endfunction

    task automatic expect_idle(input logic v, input string name);
        if (v !== 1'b0) begin
            $display("%0t ns: %s is active during or right after reset", $time, name);
            errors++;
        end
    endtask

    initial begin
        errors = 0;
        rst_h1 = 1'b0;
    end

    always @(posedge clk) begin : compare
        logic [15:0] w;
        if (!rst_n || !rst_h1) begin
            expect_idle(sdram_req, "sdram_req");
            expect_idle(rom_ready, "rom_ready");
            expect_idle(prog.we, "prog.we");
            for (int i = 0; i < NUM_SLOTS; i++) begin
                expect_idle(client_ok[i], $sformatf("client_ok[%0d]", i));
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (client_ok[i] && client_data[i] !== expected_data(i, addr_h2[i])) begin
                    $display("[FAIL] %0t ns client_data[%0d]: got %h, expected %h", $time,
                             i, client_data[i], expected_data(i, addr_h2[i]));
                    errors++;
                end
            end
            if (wr_h1 && prog !== expected_prog(waddr_h1, wdata_h1)) begin
                $display("[FAIL] %0t ns prog: got %h, expected %h", $time, prog,
                         expected_prog(waddr_h1, wdata_h1));
                errors++;
            end else if (!wr_h1 && prog.we !== 1'b0) begin
                $display("[FAIL] %0t ns prog.we: got %b, expected 0", $time, prog.we);
                errors++;
            end
            // rom_ready follows downloading two samples late
            if (dl_h2 && rom_ready !== 1'b0) begin
                $display("[FAIL] %0t ns rom_ready: got %b, expected 0", $time, rom_ready);
                errors++;
            end
            if (dl_h1 && sdram_req && !req_h1) begin
                $display("%0t ns: an SDRAM read started during a download", $time);
                errors++;
            end
        end
        if (ioctl_wr) begin
            w = stored_word(ioctl_addr >> 1);
            if (ioctl_addr[0]) begin
                w[15:8] = ioctl_data;
            end else begin
                w[7:0] = ioctl_data;
            end
            shadow[ioctl_addr >> 1] = w;
        end
        rst_h1   <= rst_n;
        addr_h1  <= client_addr;
        addr_h2  <= addr_h1;
        dl_h1    <= downloading;
        dl_h2    <= dl_h1;
        req_h1   <= sdram_req;
        wr_h1    <= ioctl_wr;
        waddr_h1 <= ioctl_addr;
        wdata_h1 <= ioctl_data;
    end

endmodule

// ==== tb_rom_fetch.sv ====
/*
  Testbench for rom_fetch_top with a behavioral SDRAM model.
  Unwritten SDRAM words read back as their low 16 address bits XOR 16'hA5C3.
*/
`timescale 1ns/10ps

module tb_rom_fetch;
    import rom_pkg::*;

    localparam int          CYCLE_LIMIT = 20000;
    localparam logic [15:0] SEED        = 16'd35671;
    localparam int          NUM_WRITES  = 24;

    logic                                clk;
    logic                                rst_n;
    logic [NUM_SLOTS-1:0]                client_cs;
    logic [NUM_SLOTS-1:0][CLIENT_AW-1:0] client_addr;
    logic [NUM_SLOTS-1:0][15:0]          client_data;
    logic [NUM_SLOTS-1:0]                client_ok;
    logic                                downloading;
    logic                                ioctl_wr;
    logic [SDRAM_AW-1:0]                 ioctl_addr;
    logic [7:0]                          ioctl_data;
    prog_wr_t                            prog;
    logic                                sdram_req;
    logic [SDRAM_AW-1:0]                 sdram_addr;
    logic                                sdram_ack;
    sdram_rd_t                           sdram_rd;
    logic                                rom_ready;

    logic [15:0]          model_lfsr;
    logic [15:0]          stim_lfsr;
    logic [15:0]          written [logic [SDRAM_AW-1:0]];
    logic [CLIENT_AW-1:0] dl_addr [$];
    int                   reads;
    int                   tb_errors;
    int                   chk_errors;
    int                   cycles;

    rom_fetch_top i_dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .client_cs   ( client_cs   ),
        .client_addr ( client_addr ),
        .client_data ( client_data ),
        .client_ok   ( client_ok   ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog        ( prog        ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .sdram_rd    ( sdram_rd    ),
        .rom_ready   ( rom_ready   )
    );

    rom_checker i_checker (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .client_addr ( client_addr ),
        .client_data ( client_data ),
        .client_ok   ( client_ok   ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog        ( prog        ),
        .sdram_req   ( sdram_req   ),
        .rom_ready   ( rom_ready   ),
        .errors      ( chk_errors  )
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], s[15]};
            s = lfsr_step(s);
        end
        return v;
    endfunction

    function automatic logic [15:0] mem_word(input logic [SDRAM_AW-1:0] a);
        if (written.exists(a)) begin
            return written[a];
        end
        return a[15:0] ^ 16'hA5C3;
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // SDRAM controller model serving one read at a time
    task automatic serve_read();
        logic [SDRAM_AW-1:0] a;
        int                  wait_ack;
        int                  wait_data;
        a         = sdram_addr;
        wait_ack  = 1 + int'(take_bits(model_lfsr, 2)) % 3;
        wait_data = 2 + int'(take_bits(model_lfsr, 2));
        reads++;
        repeat (wait_ack - 1) @(negedge clk);
        sdram_ack = 1'b1;
        @(negedge clk);
        sdram_ack = 1'b0;
        repeat (wait_data - 1) @(negedge clk);
        sdram_rd = '{rdy: 1'b1, data: {mem_word(a + 1'b1), mem_word(a)}};
        @(negedge clk);
        sdram_rd.rdy = 1'b0;
    endtask

    initial begin
        sdram_ack = 1'b0;
        sdram_rd  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && sdram_req) begin
                serve_read();
            end
        end
    end

    // Programming writes where a zero mask bit enables that byte
    always @(negedge clk) begin : prog_model
        logic [15:0] w;
        if (rst_n && prog.we) begin
            w = mem_word(prog.addr);
            if (!prog.mask[0]) begin
                w[7:0] = prog.data[7:0];
            end
            if (!prog.mask[1]) begin
                w[15:8] = prog.data[15:8];
            end
            written[prog.addr] = w;
        end
    end

    task automatic set_client(input int i, input logic [CLIENT_AW-1:0] a);
        client_cs[i]   = 1'b1;
        client_addr[i] = a;
    endtask

    // Called on the falling edge where the new addresses were driven
    task automatic wait_ok(input logic [NUM_SLOTS-1:0] which);
        int n;
        n = 0;
        repeat (2) @(negedge clk);
        while ((client_ok & which) != which && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (n >= 500) begin
            $display("Client ok never came back for clients %b", which);
            tb_errors++;
        end
    endtask

    initial begin : stimulus
        int                   start_reads;
        int                   n;
        logic [CLIENT_AW-1:0] ca;
        logic                 lane;
        rst_n       = 1'b1;
        client_cs   = '0;
        client_addr = '0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        model_lfsr  = SEED;
        stim_lfsr   = SEED;
        tb_errors   = 0;
        ca          = '0;
        lane        = 1'b0;
        #2 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // Single reads of even addresses for one client at a time
        for (int i = 0; i < NUM_SLOTS; i++) begin
            set_client(i, CLIENT_AW'(17'h00124 + i * 17'h002a6));
            wait_ok(NUM_SLOTS'(1) << i);
        end

        // Odd half of the cached word must hit
        for (int i = 0; i < NUM_SLOTS; i++) begin
            start_reads = reads;
            set_client(i, client_addr[i] | CLIENT_AW'(1));
            repeat (2) @(negedge clk);
            if (!client_ok[i] || reads != start_reads) begin
                $display("Client %0d odd half did not hit within 2 cycles", i);
                tb_errors++;
            end
        end

        // Bit 15 set so every slot misses
        start_reads = reads;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            set_client(i, {2'b01, 15'(take_bits(stim_lfsr, 15))});
        end
        wait_ok('1);
        if (reads - start_reads != NUM_SLOTS) begin
            $display("Concurrent misses gave %0d SDRAM reads instead of %0d",
                     reads - start_reads, NUM_SLOTS);
            tb_errors++;
        end

        // Download both bytes of words in the main region with bit 16 set
        downloading = 1'b1;
        repeat (2) @(negedge clk);
        // Sound client misses here and has to wait for the download to end
        set_client(1, CLIENT_AW'(17'h00400));
        for (int k = 0; k < NUM_WRITES; k++) begin
            if (k % 2 == 0) begin
                ca   = {1'b1, 16'(take_bits(stim_lfsr, 16))};
                lane = 1'(take_bits(stim_lfsr, 1));
                dl_addr.push_back(ca);
            end else begin
                lane = ~lane;
            end
            ioctl_addr = ((REGION_OFFSET[0] + SDRAM_AW'(ca)) << 1) | SDRAM_AW'(lane);
            ioctl_data = 8'(take_bits(stim_lfsr, 8));
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr   = 1'b0;
            @(negedge clk);
        end
        downloading = 1'b0;
        n = 0;
        while (!rom_ready && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rom_ready) begin
            $display("rom_ready did not return after the download");
            tb_errors++;
        end
        wait_ok(NUM_SLOTS'(2));

        foreach (dl_addr[k]) begin
            set_client(0, dl_addr[k]);
            wait_ok(NUM_SLOTS'(1));
        end

        repeat (4) @(negedge clk);
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Generous bound over the expected test length
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        tb_errors++;
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
rom_pkg.sv
rom_region_map.sv
rom_slot.sv
rom_arbiter.sv
rom_prog_loader.sv
rom_fetch_top.sv
rom_checker.sv
tb_rom_fetch.sv

// ==== Bender.yml ====
package:
  name: rom_fetch

sources:
  - files:
      - rom_pkg.sv
      - rom_region_map.sv
      - rom_slot.sv
      - rom_arbiter.sv
      - rom_prog_loader.sv
      - rom_fetch_top.sv
  - target: test
    files:
      - rom_checker.sv
      - tb_rom_fetch.sv
